// ==== files.f ====
+incdir+include
rtl/coherence_pkg.sv
rtl/dcache_pkg.sv
rtl/req_fifo.sv
rtl/dcache_mem.sv
rtl/dcache_ctrl.sv
rtl/bus_arbiter.sv
rtl/main_mem.sv
rtl/coherent_dcache_top.sv
test/coherence_checker.sv
test/tb_coherent_dcache.sv

// ==== Bender.yml ====
package:
  name: coherent_dcache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/coherence_pkg.sv
      - rtl/dcache_pkg.sv
      - rtl/req_fifo.sv
      - rtl/dcache_mem.sv
      - rtl/dcache_ctrl.sv
      - rtl/bus_arbiter.sv
      - rtl/main_mem.sv
      - rtl/coherent_dcache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/coherence_checker.sv
      - test/tb_coherent_dcache.sv

// ==== test/tb_coherent_dcache.sv ====
// directed testbench of the two-core coherent dcache, compiled with the sources in files.f
`include "dcache_macros.svh"

module tb_coherent_dcache import dcache_pkg::*; ();

	localparam int TIMEOUT = 200;
	localparam int WORDS   = 1 << `ADDR_W;

	logic               clk;
	logic               rst_n;
	logic               lq_en       [2];
	logic [`ADDR_W-1:0] lq_addr     [2];
	logic               lq_ack      [2];
	logic               lq_data_vld [2];
	word_t              lq_data     [2];
	logic               sq_en       [2];
	logic [`ADDR_W-1:0] sq_addr     [2];
	word_t              sq_data     [2];
	logic               sq_ack      [2];

	// last stored word per address, memory starts at zero
	word_t       ref_mem [WORDS];
	logic [31:0] lfsr_q;
	int          err_cnt;
	int          chk_cnt;
	int          test_err;

	coherent_dcache_top i_dut (
		.clk           (clk),
		.rst_n_i       (rst_n),
		.lq_en_i       (lq_en),
		.lq_addr_i     (lq_addr),
		.lq_ack_o      (lq_ack),
		.lq_data_vld_o (lq_data_vld),
		.lq_data_o     (lq_data),
		.sq_en_i       (sq_en),
		.sq_addr_i     (sq_addr),
		.sq_data_i     (sq_data),
		.sq_ack_o      (sq_ack)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------------------------------------
	// galois lfsr, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic logic [`ADDR_W-1:0] rand_addr();
		logic [31:0] v;
		v = rand_bits(`ADDR_W);
		return v[`ADDR_W-1:0];
	endfunction

	// --------------------------------------------------
	// core port drivers, inputs change on the falling edge
	task automatic do_store(input int core, input logic [`ADDR_W-1:0] addr, input word_t data);
		int n;
		n = 0;
		@(negedge clk);
		sq_en[core]   = 1'b1;
		sq_addr[core] = addr;
		sq_data[core] = data;
		@(posedge clk);
		while (!sq_ack[core] && n < TIMEOUT) begin
			n++;
			@(posedge clk);
		end
		if (sq_ack[core]) begin
			ref_mem[addr] = data;
		end else begin
			$display("timeout: core %0d store to %h was never acked", core, addr);
			err_cnt++;
		end
		@(negedge clk);
		sq_en[core] = 1'b0;
	endtask

	task automatic do_load(input int core, input logic [`ADDR_W-1:0] addr,
	                       output word_t data, output logic hit, output logic ok);
		int   n;
		logic acked;
		n     = 0;
		hit   = 1'b0;
		ok    = 1'b0;
		data  = '0;
		@(negedge clk);
		lq_en[core]   = 1'b1;
		lq_addr[core] = addr;
		@(posedge clk);
		while (!lq_ack[core] && n < TIMEOUT) begin
			n++;
			@(posedge clk);
		end
		acked = lq_ack[core];
		if (acked && lq_data_vld[core]) begin
			hit  = 1'b1;
			ok   = 1'b1;
			data = lq_data[core];
		end
		@(negedge clk);
		lq_en[core] = 1'b0;
		// a miss returns its word later with the fill
		n = 0;
		while (acked && !ok && n < TIMEOUT) begin
			@(posedge clk);
			n++;
			if (lq_data_vld[core]) begin
				ok   = 1'b1;
				data = lq_data[core];
			end
		end
		if (!acked)
			$display("timeout: core %0d load from %h was never acked", core, addr);
		else if (!ok)
			$display("timeout: core %0d load from %h never returned data", core, addr);
		if (!ok)
			err_cnt++;
	endtask

	task automatic expect_load(input int core, input logic [`ADDR_W-1:0] addr,
	                           input logic need_hit);
		word_t got;
		logic  hit;
		logic  ok;
		do_load(core, addr, got, hit, ok);
		chk_cnt++;
		if (ok && got !== ref_mem[addr]) begin
			$display("[ERROR] lq_data_o[%0d] addr %h: got %h, expected %h",
			         core, addr, got, ref_mem[addr]);
			err_cnt++;
		end
		if (ok && need_hit && !hit) begin
			$display("core %0d load from %h missed where a same-cycle hit was due", core, addr);
			err_cnt++;
		end
	endtask

	task automatic report_test(input string name);
		if (err_cnt == test_err)
			$display("%s: ok", name);
		else
			$display("%s: %0d failing checks", name, err_cnt - test_err);
		test_err = err_cnt;
	endtask

	// --------------------------------------------------
	// directed tests
	task automatic test_reset_zero();
		rst_n = 1'b0;
		repeat (2) begin
			@(posedge clk);
			for (int c = 0; c < 2; c++) begin
				chk_cnt++;
				if (lq_ack[c] || lq_data_vld[c] || sq_ack[c]) begin
					$display("core %0d raised an ack or data valid during reset", c);
					err_cnt++;
				end
			end
		end
		@(negedge clk);
		rst_n = 1'b1;
		expect_load(0, rand_addr(), 1'b0);
		expect_load(1, rand_addr(), 1'b0);
		report_test("reset and zero load");
	endtask

	task automatic test_store_load();
		do_store(0, 8'h21, rand_bits(32));
		expect_load(0, 8'h21, 1'b0);
		expect_load(0, 8'h21, 1'b1);
		report_test("store then load");
	endtask

	task automatic test_owner_supply();
		do_store(0, 8'h32, rand_bits(32));
		expect_load(0, 8'h32, 1'b1);
		expect_load(1, 8'h32, 1'b0);
		expect_load(0, 8'h32, 1'b1);
		report_test("owner supplies data");
	endtask

	task automatic test_invalidate();
		do_store(1, 8'h32, rand_bits(32));
		expect_load(1, 8'h32, 1'b0);
		expect_load(0, 8'h32, 1'b0);
		report_test("store invalidates sharer");
	endtask

	task automatic test_victim_writeback();
		// same index, two tags
		do_store(0, 8'h43, rand_bits(32));
		do_store(0, 8'h53, rand_bits(32));
		expect_load(0, 8'h43, 1'b0);
		expect_load(1, 8'h53, 1'b0);
		report_test("dirty victim write-back");
	endtask

	task automatic test_concurrent_stores();
		logic [`ADDR_W-1:0] a0;
		logic [`ADDR_W-1:0] a1;
		word_t              d0;
		word_t              d1;
		logic [`ADDR_W-1:0] seen0 [4];
		logic [`ADDR_W-1:0] seen1 [4];
		for (int r = 0; r < 4; r++) begin
			a0 = rand_addr();
			a1 = rand_addr();
			if (a1 == a0)
				a1[0] = ~a1[0];
			d0 = rand_bits(32);
			d1 = rand_bits(32);
			seen0[r] = a0;
			seen1[r] = a1;
			fork
				do_store(0, a0, d0);
				do_store(1, a1, d1);
			join
			// own reads wait for each fill, so rounds do not overlap
			fork
				expect_load(0, a0, 1'b0);
				expect_load(1, a1, 1'b0);
			join
		end
		for (int r = 0; r < 4; r++) begin
			expect_load(0, seen1[r], 1'b0);
			expect_load(1, seen0[r], 1'b0);
		end
		report_test("concurrent random stores");
	endtask

	initial begin
		lfsr_q   = 32'd80207;
		err_cnt  = 0;
		chk_cnt  = 0;
		test_err = 0;
		rst_n    = 1'b0;
		for (int c = 0; c < 2; c++) begin
			lq_en[c]   = 1'b0;
			lq_addr[c] = '0;
			sq_en[c]   = 1'b0;
			sq_addr[c] = '0;
			sq_data[c] = '0;
		end
		for (int i = 0; i < WORDS; i++)
			ref_mem[i] = '0;
		test_reset_zero();
		test_store_load();
		test_owner_supply();
		test_invalidate();
		test_victim_writeback();
		test_concurrent_stores();
		$display("checks: %0d, failing: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule : tb_coherent_dcache

// ==== test/coherence_checker.sv ====
// bus and coherence assertions, bound into the dcache top level for simulation
`include "dcache_macros.svh"

module coherence_checker import coherence_pkg::*, dcache_pkg::*; #(
	parameter int LINES = 1 << `DCACHE_IDX_W
) (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        gnt_i      [2],
	input  logic        busy_i,
	input  logic        rsp_vld_i,
	input  logic        lq_ack_i   [2],
	input  logic        sq_ack_i   [2],
	input  line_state_t state0_i   [LINES],
	input  line_state_t state1_i   [LINES],
	input  tag_t        tag0_i     [LINES],
	input  tag_t        tag1_i     [LINES]
);

	logic two_owners;

	// same tag held dirty on both sides
	always_comb begin
		two_owners = 1'b0;
		for (int i = 0; i < LINES; i++)
			if (state0_i[i] == MODIFIED && state1_i[i] == MODIFIED && tag0_i[i] == tag1_i[i])
				two_owners = 1'b1;
	end

	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(gnt_i[0] && gnt_i[1]))
		else $error("both cores granted in one cycle");

	a_rsp_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
		rsp_vld_i |-> busy_i)
		else $error("bus response while the bus is idle");

	a_reset_quiet: assert property (@(posedge clk)
		!rst_n_i |-> !(lq_ack_i[0] || lq_ack_i[1] || sq_ack_i[0] || sq_ack_i[1]))
		else $error("ack raised during reset");

	a_single_owner: assert property (@(posedge clk) disable iff (!rst_n_i)
		!two_owners)
		else $error("line held in MODIFIED by both caches");

endmodule : coherence_checker

bind coherent_dcache_top coherence_checker i_checker (
	.clk       (clk),
	.rst_n_i   (rst_n_i),
	.gnt_i     (bus_gnt),
	.busy_i    (i_arb.busy_q),
	.rsp_vld_i (rsp_vld),
	.lq_ack_i  (lq_ack_o),
	.sq_ack_i  (sq_ack_o),
	.state0_i  (g_core[0].i_ctrl.i_mem.state_q),
	.state1_i  (g_core[1].i_ctrl.i_mem.state_q),
	.tag0_i    (g_core[0].i_ctrl.i_mem.tag_q),
	.tag1_i    (g_core[1].i_ctrl.i_mem.tag_q)
);

// ==== rtl/coherent_dcache_top.sv ====
// top level of the two-core coherent dcache, with two controllers, the bus arbiter and memory
`include "dcache_macros.svh"

module coherent_dcache_top import coherence_pkg::*, dcache_pkg::*; (
	input  logic               clk,
	input  logic               rst_n_i,

	input  logic               lq_en_i       [2],
	input  logic [`ADDR_W-1:0] lq_addr_i     [2],
	output logic               lq_ack_o      [2],
	output logic               lq_data_vld_o [2],
	output word_t              lq_data_o     [2],

	input  logic               sq_en_i       [2],
	input  logic [`ADDR_W-1:0] sq_addr_i     [2],
	input  word_t              sq_data_i     [2],
	output logic               sq_ack_o      [2]
);

	// request side, one entry per core
	logic     bus_req      [2];
	tag_t     bus_req_tag  [2];
	idx_t     bus_req_idx  [2];
	word_t    bus_req_data [2];
	message_t bus_req_msg  [2];
	logic     bus_gnt      [2];
	logic     owner_vld    [2];
	word_t    owner_data   [2];

	// broadcast side
	logic     snoop_vld;
	logic     snoop_id;
	tag_t     snoop_tag;
	idx_t     snoop_idx;
	message_t snoop_msg;
	word_t    snoop_data;
	logic     mem_rsp_vld;
	word_t    mem_rsp_data;
	logic     rsp_vld;
	logic     rsp_id;
	word_t    rsp_data;

	for (genvar i = 0; i < 2; i++) begin : g_core
		dcache_ctrl i_ctrl (
			.clk            (clk),
			.rst_n_i        (rst_n_i),
			.cpu_id_i       (1'(i)),
			.lq_en_i        (lq_en_i[i]),
			.lq_addr_i      (lq_addr_i[i]),
			.lq_ack_o       (lq_ack_o[i]),
			.lq_data_vld_o  (lq_data_vld_o[i]),
			.lq_data_o      (lq_data_o[i]),
			.sq_en_i        (sq_en_i[i]),
			.sq_addr_i      (sq_addr_i[i]),
			.sq_data_i      (sq_data_i[i]),
			.sq_ack_o       (sq_ack_o[i]),
			.bus_req_o      (bus_req[i]),
			.bus_req_tag_o  (bus_req_tag[i]),
			.bus_req_idx_o  (bus_req_idx[i]),
			.bus_req_data_o (bus_req_data[i]),
			.bus_req_msg_o  (bus_req_msg[i]),
			.bus_gnt_i      (bus_gnt[i]),
			.snoop_vld_i    (snoop_vld),
			.snoop_id_i     (snoop_id),
			.snoop_tag_i    (snoop_tag),
			.snoop_idx_i    (snoop_idx),
			.snoop_msg_i    (snoop_msg),
			.owner_vld_o    (owner_vld[i]),
			.owner_data_o   (owner_data[i]),
			.rsp_vld_i      (rsp_vld),
			.rsp_id_i       (rsp_id),
			.rsp_data_i     (rsp_data)
		);
	end

	bus_arbiter i_arb (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.req_i          (bus_req),
		.req_tag_i      (bus_req_tag),
		.req_idx_i      (bus_req_idx),
		.req_data_i     (bus_req_data),
		.req_msg_i      (bus_req_msg),
		.gnt_o          (bus_gnt),
		.snoop_vld_o    (snoop_vld),
		.snoop_id_o     (snoop_id),
		.snoop_tag_o    (snoop_tag),
		.snoop_idx_o    (snoop_idx),
		.snoop_msg_o    (snoop_msg),
		.snoop_data_o   (snoop_data),
		.owner_vld_i    (owner_vld),
		.owner_data_i   (owner_data),
		.mem_rsp_vld_i  (mem_rsp_vld),
		.mem_rsp_data_i (mem_rsp_data),
		.rsp_vld_o      (rsp_vld),
		.rsp_id_o       (rsp_id),
		.rsp_data_o     (rsp_data)
	);

	main_mem i_mem (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.snoop_vld_i  (snoop_vld),
		.snoop_tag_i  (snoop_tag),
		.snoop_idx_i  (snoop_idx),
		.snoop_msg_i  (snoop_msg),
		.snoop_data_i (snoop_data),
		.owner_vld_i  (owner_vld[0] || owner_vld[1]),
		.rsp_vld_o    (mem_rsp_vld),
		.rsp_data_o   (mem_rsp_data)
	);

endmodule : coherent_dcache_top

// ==== rtl/main_mem.sv ====
// word-addressed backing memory behind the bus with fixed read latency and a write-back buffer
`include "dcache_macros.svh"

module main_mem import coherence_pkg::*, dcache_pkg::*; (
	input  logic     clk,
	input  logic     rst_n_i,
	input  logic     snoop_vld_i,
	input  tag_t     snoop_tag_i,
	input  idx_t     snoop_idx_i,
	input  message_t snoop_msg_i,
	input  word_t    snoop_data_i,
	input  logic     owner_vld_i,
	output logic     rsp_vld_o,
	output word_t    rsp_data_o
);

	localparam int WORDS = 1 << `ADDR_W;
	localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

	word_t              mem_q [WORDS];
	logic               is_get;
	logic               wb_push;
	wb_entry_t          wb_in;
	wb_entry_t          wb_head;
	logic               wb_empty;
	logic               busy_q;
	logic [CNT_W-1:0]   cnt_q;
	logic [`ADDR_W-1:0] addr_q;

	assign is_get  = snoop_vld_i && (snoop_msg_i == GET_S || snoop_msg_i == GET_M);
	assign wb_push = snoop_vld_i && (snoop_msg_i == PUT_M || (is_get && owner_vld_i));
	assign wb_in   = '{addr: {snoop_tag_i, snoop_idx_i}, data: snoop_data_i};

	// drained one entry per cycle
	req_fifo #(
		.T     (wb_entry_t),
		.DEPTH (`WB_DEPTH)
	) i_wb_buf (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.push_i      (wb_push),
		.push_data_i (wb_in),
		.pop_i       (!wb_empty),
		.head_o      (wb_head),
		.empty_o     (wb_empty),
		.full_o      ()
	);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < WORDS; i++)
				mem_q[i] <= '0;
		end else if (!wb_empty) begin
			mem_q[wb_head.addr] <= wb_head.data;
		end
	end

	// --------------------------------------------------
	// read latency, only when no cache owns the line
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (is_get && !owner_vld_i) begin
			busy_q <= 1'b1;
			cnt_q  <= CNT_W'(`MEM_LATENCY - 1);
		end else if (busy_q) begin
			if (cnt_q == '0)
				busy_q <= 1'b0;
			else
				cnt_q <= cnt_q - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (is_get)
			addr_q <= {snoop_tag_i, snoop_idx_i};
	end

	assign rsp_vld_o  = busy_q && (cnt_q == '0);
	assign rsp_data_o = mem_q[addr_q];

endmodule : main_mem

// ==== rtl/bus_arbiter.sv ====
// round-robin arbiter of the atomic snooping bus, broadcasting grants and returning responses
`include "dcache_macros.svh"

module bus_arbiter import coherence_pkg::*, dcache_pkg::*; (
	input  logic     clk,
	input  logic     rst_n_i,

	input  logic     req_i        [2],
	input  tag_t     req_tag_i    [2],
	input  idx_t     req_idx_i    [2],
	input  word_t    req_data_i   [2],
	input  message_t req_msg_i    [2],
	output logic     gnt_o        [2],

	output logic     snoop_vld_o,
	output logic     snoop_id_o,
	output tag_t     snoop_tag_o,
	output idx_t     snoop_idx_o,
	output message_t snoop_msg_o,
	output word_t    snoop_data_o,

	input  logic     owner_vld_i  [2],
	input  word_t    owner_data_i [2],
	input  logic     mem_rsp_vld_i,
	input  word_t    mem_rsp_data_i,

	output logic     rsp_vld_o,
	output logic     rsp_id_o,
	output word_t    rsp_data_o
);

	logic  rr_q;
	logic  busy_q;
	logic  rsp_id_q;
	logic  own_vld_q;
	word_t own_data_q;
	logic  grant;
	logic  win;
	logic  owner_any;
	word_t owner_data;

	// rr_q names the core that wins a tie
	assign grant = (req_i[0] || req_i[1]) && !busy_q;
	assign win   = (req_i[0] && req_i[1]) ? rr_q : req_i[1];

	assign gnt_o[0] = grant && !win;
	assign gnt_o[1] = grant && win;

	assign snoop_vld_o = grant;
	assign snoop_id_o  = win;
	assign snoop_tag_o = req_tag_i[win];
	assign snoop_idx_o = req_idx_i[win];
	assign snoop_msg_o = req_msg_i[win];

	// owner data rides the snoop data lines so memory stays current
	assign owner_any    = owner_vld_i[0] || owner_vld_i[1];
	assign owner_data   = owner_vld_i[1] ? owner_data_i[1] : owner_data_i[0];
	assign snoop_data_o = owner_any ? owner_data : req_data_i[win];

	assign rsp_vld_o  = own_vld_q || mem_rsp_vld_i;
	assign rsp_data_o = own_vld_q ? own_data_q : mem_rsp_data_i;
	assign rsp_id_o   = rsp_id_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rr_q      <= 1'b0;
			busy_q    <= 1'b0;
			rsp_id_q  <= 1'b0;
			own_vld_q <= 1'b0;
		end else begin
			own_vld_q <= owner_any;
			if (grant) begin
				rr_q     <= !win;
				rsp_id_q <= win;
			end
			// PUT_M frees the bus in its grant cycle
			if (grant && req_msg_i[win] != PUT_M)
				busy_q <= 1'b1;
			else if (rsp_vld_o)
				busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		own_data_q <= owner_data;
	end

endmodule : bus_arbiter

// ==== rtl/dcache_ctrl.sv ====
// per-core dcache controller serving the load and store ports and the snooping bus
`include "dcache_macros.svh"

module dcache_ctrl import coherence_pkg::*, dcache_pkg::*; (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               cpu_id_i,

	input  logic               lq_en_i,
	input  logic [`ADDR_W-1:0] lq_addr_i,
	output logic               lq_ack_o,
	output logic               lq_data_vld_o,
	output word_t              lq_data_o,

	input  logic               sq_en_i,
	input  logic [`ADDR_W-1:0] sq_addr_i,
	input  word_t              sq_data_i,
	output logic               sq_ack_o,

	output logic               bus_req_o,
	output tag_t               bus_req_tag_o,
	output idx_t               bus_req_idx_o,
	output word_t              bus_req_data_o,
	output message_t           bus_req_msg_o,
	input  logic               bus_gnt_i,

	input  logic               snoop_vld_i,
	input  logic               snoop_id_i,
	input  tag_t               snoop_tag_i,
	input  idx_t               snoop_idx_i,
	input  message_t           snoop_msg_i,
	output logic               owner_vld_o,
	output word_t              owner_data_o,

	input  logic               rsp_vld_i,
	input  logic               rsp_id_i,
	input  word_t              rsp_data_i
);

	localparam int LINES = 1 << `DCACHE_IDX_W;

	tag_t        lq_tag;
	idx_t        lq_idx;
	tag_t        sq_tag;
	idx_t        sq_idx;
	logic        lk_hit;
	line_state_t lk_state;
	word_t       lk_data;
	logic        st_en;
	logic        load_hit;
	logic        fill_en;
	word_t       fill_data;
	line_state_t fill_state;
	line_state_t vic_state;
	tag_t        vic_tag;
	word_t       vic_data;
	line_state_t sn_state;
	word_t       sn_data;
	logic        sn_set_en;
	line_state_t sn_new_state;
	logic        other_snoop;
	logic        snoop_get;
	logic        need_put;
	logic        block;
	logic        push;
	miss_req_t   push_data;
	miss_req_t   head;
	logic        q_empty;
	logic        q_full;

	// head of queue granted a GET, waiting for its response
	logic              wait_q;
	// one bit per index with a miss in the queue
	logic [LINES-1:0]  pend_q;

	assign {lq_tag, lq_idx} = lq_addr_i;
	assign {sq_tag, sq_idx} = sq_addr_i;

	dcache_mem i_mem (
		.clk               (clk),
		.rst_n_i           (rst_n_i),
		.lk_tag_i          (sq_en_i ? sq_tag : lq_tag),
		.lk_idx_i          (sq_en_i ? sq_idx : lq_idx),
		.lk_hit_o          (lk_hit),
		.lk_state_o        (lk_state),
		.lk_data_o         (lk_data),
		.st_en_i           (st_en),
		.st_idx_i          (sq_idx),
		.st_data_i         (sq_data_i),
		.fill_en_i         (fill_en),
		.fill_tag_i        (head.tag),
		.fill_idx_i        (head.idx),
		.fill_data_i       (fill_data),
		.fill_state_i      (fill_state),
		.vic_idx_i         (head.idx),
		.vic_state_o       (vic_state),
		.vic_tag_o         (vic_tag),
		.vic_data_o        (vic_data),
		.sn_tag_i          (snoop_tag_i),
		.sn_idx_i          (snoop_idx_i),
		.sn_state_o        (sn_state),
		.sn_data_o         (sn_data),
		.sn_set_state_en_i (sn_set_en),
		.sn_new_state_i    (sn_new_state)
	);

	req_fifo #(
		.T     (miss_req_t),
		.DEPTH (`MSHR_DEPTH)
	) i_mshr (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.push_i      (push),
		.push_data_i (push_data),
		.pop_i       (fill_en),
		.head_o      (head),
		.empty_o     (q_empty),
		.full_o      (q_full)
	);

	// --------------------------------------------------
	// response fill, a GET_M merges the queued store word
	assign fill_en    = rsp_vld_i && (rsp_id_i == cpu_id_i) && wait_q;
	assign fill_data  = (head.msg == GET_M) ? head.data : rsp_data_i;
	assign fill_state = (head.msg == GET_M) ? MODIFIED : SHARED;

	// --------------------------------------------------
	// snoop side
	assign other_snoop  = snoop_vld_i && (snoop_id_i != cpu_id_i);
	assign snoop_get    = other_snoop && (snoop_msg_i == GET_S || snoop_msg_i == GET_M);
	assign owner_vld_o  = snoop_get && (sn_state == MODIFIED);
	assign owner_data_o = sn_data;
	// own PUT_M grant drops the victim, broadcast fields point at it
	assign sn_set_en    = (snoop_get && sn_state != INVALID) ||
	                      (bus_gnt_i && bus_req_msg_o == PUT_M);
	assign sn_new_state = (snoop_msg_i == GET_S) ? SHARED : INVALID;

	// --------------------------------------------------
	// request issue, dirty victim goes out first
	assign need_put       = (vic_state == MODIFIED) && (vic_tag != head.tag);
	assign bus_req_o      = !q_empty && !wait_q;
	assign bus_req_tag_o  = need_put ? vic_tag : head.tag;
	assign bus_req_idx_o  = head.idx;
	assign bus_req_data_o = need_put ? vic_data : head.data;
	assign bus_req_msg_o  = need_put ? PUT_M : head.msg;

	// --------------------------------------------------
	// core ports, held off while the arrays change under a fill or snoop
	assign block = fill_en || other_snoop;

	always_comb begin
		lq_ack_o  = 1'b0;
		sq_ack_o  = 1'b0;
		st_en     = 1'b0;
		load_hit  = 1'b0;
		push      = 1'b0;
		push_data = '{tag: sq_tag, idx: sq_idx, data: sq_data_i, msg: GET_M};
		if (sq_en_i) begin
			if (!block && !pend_q[sq_idx]) begin
				if (lk_hit && lk_state == MODIFIED) begin
					sq_ack_o = 1'b1;
					st_en    = 1'b1;
				end else if (!q_full) begin
					sq_ack_o = 1'b1;
					push     = 1'b1;
				end
			end
		end else if (lq_en_i && !block && !pend_q[lq_idx]) begin
			if (lk_hit) begin
				lq_ack_o = 1'b1;
				load_hit = 1'b1;
			end else if (!q_full) begin
				lq_ack_o  = 1'b1;
				push      = 1'b1;
				push_data = '{tag: lq_tag, idx: lq_idx, data: '0, msg: GET_S};
			end
		end
	end

	assign lq_data_vld_o = load_hit || (fill_en && head.msg == GET_S);
	assign lq_data_o     = fill_en ? rsp_data_i : lk_data;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wait_q <= 1'b0;
			pend_q <= '0;
		end else begin
			if (bus_gnt_i && bus_req_msg_o != PUT_M)
				wait_q <= 1'b1;
			else if (fill_en)
				wait_q <= 1'b0;
			if (push)
				pend_q[push_data.idx] <= 1'b1;
			if (fill_en)
				pend_q[head.idx] <= 1'b0;
		end
	end

endmodule : dcache_ctrl

// ==== rtl/dcache_mem.sv ====
// tag, state and data arrays of one direct-mapped cache, read combinationally by the controller
`include "dcache_macros.svh"

module dcache_mem import coherence_pkg::*, dcache_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,

	// core lookup
	input  tag_t        lk_tag_i,
	input  idx_t        lk_idx_i,
	output logic        lk_hit_o,
	output line_state_t lk_state_o,
	output word_t       lk_data_o,

	// store hit, line becomes MODIFIED
	input  logic        st_en_i,
	input  idx_t        st_idx_i,
	input  word_t       st_data_i,

	// fill from bus response
	input  logic        fill_en_i,
	input  tag_t        fill_tag_i,
	input  idx_t        fill_idx_i,
	input  word_t       fill_data_i,
	input  line_state_t fill_state_i,

	// victim read for write-back
	input  idx_t        vic_idx_i,
	output line_state_t vic_state_o,
	output tag_t        vic_tag_o,
	output word_t       vic_data_o,

	// snoop lookup and state change
	input  tag_t        sn_tag_i,
	input  idx_t        sn_idx_i,
	output line_state_t sn_state_o,
	output word_t       sn_data_o,
	input  logic        sn_set_state_en_i,
	input  line_state_t sn_new_state_i
);

	localparam int LINES = 1 << `DCACHE_IDX_W;

	tag_t        tag_q   [LINES];
	line_state_t state_q [LINES];
	word_t       data_q  [LINES];

	assign lk_hit_o   = (state_q[lk_idx_i] != INVALID) && (tag_q[lk_idx_i] == lk_tag_i);
	assign lk_state_o = state_q[lk_idx_i];
	assign lk_data_o  = data_q[lk_idx_i];

	assign vic_state_o = state_q[vic_idx_i];
	assign vic_tag_o   = tag_q[vic_idx_i];
	assign vic_data_o  = data_q[vic_idx_i];

	// a tag mismatch looks like an invalid line to the snooper
	assign sn_state_o = (tag_q[sn_idx_i] == sn_tag_i) ? state_q[sn_idx_i] : INVALID;
	assign sn_data_o  = data_q[sn_idx_i];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < LINES; i++)
				state_q[i] <= INVALID;
		end else begin
			if (st_en_i)
				state_q[st_idx_i] <= MODIFIED;
			if (sn_set_state_en_i)
				state_q[sn_idx_i] <= sn_new_state_i;
			if (fill_en_i)
				state_q[fill_idx_i] <= fill_state_i;
		end
	end

	always_ff @(posedge clk) begin
		if (st_en_i)
			data_q[st_idx_i] <= st_data_i;
		if (fill_en_i) begin
			tag_q[fill_idx_i]  <= fill_tag_i;
			data_q[fill_idx_i] <= fill_data_i;
		end
	end

endmodule : dcache_mem

// ==== rtl/req_fifo.sv ====
// circular request queue with a type parameter, used as miss queue and write-back buffer
module req_fifo #(
	parameter type T     = logic,
	parameter int  DEPTH = 4
) (
	input  logic clk,
	input  logic rst_n_i,
	input  logic push_i,
	input  T     push_data_i,
	input  logic pop_i,
	output T     head_o,
	output logic empty_o,
	output logic full_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T                 mem_q [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] cnt_q;
	logic             do_push;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty_o = (cnt_q == '0);
	assign full_o  = (cnt_q == CNT_W'(DEPTH));
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;
	assign head_o  = mem_q[rd_ptr_q];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			cnt_q    <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= next_ptr(wr_ptr_q);
			if (do_pop)
				rd_ptr_q <= next_ptr(rd_ptr_q);
			cnt_q <= cnt_q + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem_q[wr_ptr_q] <= push_data_i;
	end

endmodule : req_fifo

// ==== rtl/dcache_pkg.sv ====
// address field and queue payload types of the dcache, imported by the rtl modules
`include "dcache_macros.svh"

package dcache_pkg;
	import coherence_pkg::*;

	typedef logic [`DCACHE_TAG_W-1:0]  tag_t;
	typedef logic [`DCACHE_IDX_W-1:0]  idx_t;
	typedef logic [`DCACHE_WORD_W-1:0] word_t;

	// one outstanding miss, data only meaningful for GET_M
	typedef struct packed {
		tag_t     tag;
		idx_t     idx;
		word_t    data;
		message_t msg;
	} miss_req_t;

	// word on its way into main memory
	typedef struct packed {
		logic [`ADDR_W-1:0] addr;
		word_t              data;
	} wb_entry_t;

endpackage : dcache_pkg

// ==== rtl/coherence_pkg.sv ====
// bus message and MSI line state encodings, imported by the caches, arbiter and memory
package coherence_pkg;

	// snooping bus messages
	typedef enum logic [1:0] {
		NONE  = 2'd0,
		GET_S = 2'd1,
		GET_M = 2'd2,
		PUT_M = 2'd3
	} message_t;

	// MSI states of a cache line
	typedef enum logic [1:0] {
		INVALID  = 2'd0,
		SHARED   = 2'd1,
		MODIFIED = 2'd2
	} line_state_t;

endpackage : coherence_pkg

// ==== include/dcache_macros.svh ====
// widths, queue depths and memory latency of the dcache subsystem, included by rtl and testbench
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// address split into tag and index, one word per line
`define DCACHE_TAG_W    4
`define DCACHE_IDX_W    4
`define DCACHE_WORD_W   32
`define ADDR_W          (`DCACHE_TAG_W + `DCACHE_IDX_W)

// queue depths
`define MSHR_DEPTH      4
`define WB_DEPTH        2

// cycles from bus grant to memory response
`define MEM_LATENCY     3

`endif
